//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_game_pace
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf $(OBJ_DIR)

//--- filelist.f
hdl/pace_pkg.sv
hdl/pace_regs_pkg.sv
hdl/difficulty_ramp.sv
hdl/pace_timer.sv
hdl/pace_regs.sv
hdl/game_pace_top.sv
testbench/game_pace_props.sv
testbench/tb_game_pace.sv

//--- hdl/difficulty_ramp.sv
`timescale 1ns/100ps
`default_nettype none

module difficulty_ramp (
    input  wire                clock,
    input  wire                rst_n,
    input  wire                clr,
    input  wire                ld,
    input  wire                ent,
    input  wire                enp,
    input  wire pace_pkg::elapsed_t load_value,
    output pace_pkg::elapsed_t elapsed,
    output logic               done,
    output pace_pkg::level_t   level,
    output pace_pkg::period_t  period_spawn,
    output pace_pkg::period_t  period_aster,
    output pace_pkg::period_t  period_shot
);

    import pace_pkg::*;

    // first elapsed value that belongs to the top level
    localparam elapsed_t top_level_start = elapsed_t'((num_levels - 1) * step_cycles);
    localparam level_t   top_level       = level_t'(num_levels - 1);

    logic     at_max;
    level_t   level_next;
    elapsed_t load_clamped;

    assign at_max = (elapsed >= elapsed_max);

    // a host value past the end of the ramp is pinned to the end
    assign load_clamped = (load_value > elapsed_max) ? elapsed_max : load_value;

    //////////////////////////////
    // elapsed counter
    //////////////////////////////

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            elapsed <= '0;
        end else if (clr) begin
            elapsed <= '0;
        end else if (ld) begin
            elapsed <= load_clamped;
        end else if (ent && enp && !at_max) begin
            elapsed <= elapsed + 1'b1;
        end
    end

    assign done = ent && at_max;  // carry style, only while the trickle enable is up

    //////////////////////////////
    // level decode and lookup
    //////////////////////////////

    // step_cycles is a power of two so the quotient is a bit slice
    always_comb begin
        if (elapsed >= top_level_start) begin
            level_next = top_level;
        end else begin
            level_next = level_t'(elapsed / elapsed_t'(step_cycles));
        end
    end

    // periods index with level_next so they line up with the level register
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            level        <= '0;
            period_spawn <= period_table[chan_spawn][0];
            period_aster <= period_table[chan_aster][0];
            period_shot  <= period_table[chan_shot][0];
        end else begin
            level        <= level_next;
            period_spawn <= period_table[chan_spawn][level_next];
            period_aster <= period_table[chan_aster][level_next];
            period_shot  <= period_table[chan_shot][level_next];
        end
    end

endmodule

`default_nettype wire

//--- hdl/game_pace_top.sv
`timescale 1ns/100ps
`default_nettype none

module game_pace_top (
    input  wire                     clock,
    input  wire                     rst_n,
    input  wire                     wb_cyc,
    input  wire                     wb_stb,
    input  wire                     wb_we,
    input  wire pace_regs_pkg::wb_addr_t wb_adr,
    input  wire pace_regs_pkg::wb_data_t wb_dat_w,
    output pace_regs_pkg::wb_data_t wb_dat_r,
    output logic                    wb_ack,
    output logic [pace_pkg::num_channels-1:0] ticks
);

    import pace_pkg::*;

    logic     run;
    logic     clr;
    logic     ld;
    logic     done;
    elapsed_t load_value;
    elapsed_t elapsed;
    level_t   level;
    period_t  period_spawn;
    period_t  period_aster;
    period_t  period_shot;
    period_t  period_ch [num_channels];

    difficulty_ramp u_ramp (
        .clock        (clock),
        .rst_n        (rst_n),
        .clr          (clr),
        .ld           (ld),
        .ent          (run),
        .enp          (run),
        .load_value   (load_value),
        .elapsed      (elapsed),
        .done         (done),
        .level        (level),
        .period_spawn (period_spawn),
        .period_aster (period_aster),
        .period_shot  (period_shot)
    );

    assign period_ch[chan_spawn] = period_spawn;
    assign period_ch[chan_aster] = period_aster;
    assign period_ch[chan_shot]  = period_shot;

    // one timer per channel, indexed like the tick counters
    for (genvar k = 0; k < num_channels; k++) begin : g_timer
        pace_timer u_timer (
            .clock  (clock),
            .rst_n  (rst_n),
            .clr    (clr),
            .run    (run),
            .period (period_ch[k]),
            .tick   (ticks[k])
        );
    end

    pace_regs u_regs (
        .clock      (clock),
        .rst_n      (rst_n),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat_w   (wb_dat_w),
        .wb_dat_r   (wb_dat_r),
        .wb_ack     (wb_ack),
        .elapsed    (elapsed),
        .level      (level),
        .done       (done),
        .ticks      (ticks),
        .run        (run),
        .clr        (clr),
        .ld         (ld),
        .load_value (load_value)
    );

endmodule

`default_nettype wire

//--- hdl/pace_pkg.sv
`default_nettype none

package pace_pkg;

    //////////////////////////////
    // widths with a meaning
    //////////////////////////////

    typedef logic [15:0] elapsed_t;  // elapsed play time in clock cycles
    typedef logic [3:0]  level_t;    // difficulty level, 0 is the easiest
    typedef logic [15:0] period_t;   // cycles between two ticks of one channel

    //////////////////////////////
    // ramp constants
    //////////////////////////////

    localparam int num_levels  = 12;
    localparam int step_cycles = 64;  // one level step per 64 elapsed cycles

    localparam elapsed_t elapsed_max = elapsed_t'(num_levels * step_cycles);

    localparam int num_channels = 3;
    localparam int chan_spawn   = 0;  // asteroid spawn
    localparam int chan_aster   = 1;  // asteroid move
    localparam int chan_shot    = 2;  // shot move

    //////////////////////////////
    // period table
    //////////////////////////////

    // row per channel, column per level, every row strictly decreasing
    // values are scaled down so that a full ramp fits in a short simulation
    localparam period_t period_table [num_channels][num_levels] = '{
        '{
            16'd48, 16'd44, 16'd41, 16'd38, 16'd35, 16'd32,
            16'd29, 16'd26, 16'd23, 16'd20, 16'd16, 16'd13
        },
        '{
            16'd32, 16'd30, 16'd28, 16'd26, 16'd23, 16'd21,
            16'd19, 16'd17, 16'd15, 16'd13, 16'd11, 16'd9
        },
        '{
            16'd20, 16'd18, 16'd16, 16'd15, 16'd13, 16'd12,
            16'd10, 16'd9,  16'd8,  16'd6,  16'd5,  16'd4
        }
    };

endpackage

`default_nettype wire

//--- hdl/pace_regs.sv
`timescale 1ns/100ps
`default_nettype none

module pace_regs (
    input  wire                     clock,
    input  wire                     rst_n,
    input  wire                     wb_cyc,
    input  wire                     wb_stb,
    input  wire                     wb_we,
    input  wire pace_regs_pkg::wb_addr_t wb_adr,
    input  wire pace_regs_pkg::wb_data_t wb_dat_w,
    output pace_regs_pkg::wb_data_t wb_dat_r,
    output logic                    wb_ack,
    input  wire pace_pkg::elapsed_t elapsed,
    input  wire pace_pkg::level_t   level,
    input  wire                     done,
    input  wire [pace_pkg::num_channels-1:0] ticks,
    output logic                    run,
    output logic                    clr,
    output logic                    ld,
    output pace_pkg::elapsed_t      load_value
);

    import pace_pkg::*;
    import pace_regs_pkg::*;

    logic     req;
    logic     wr;
    logic     wr_ctrl;
    wb_data_t rdata;

    logic [num_channels-1:0] tick_sel;
    wb_data_t                tick_count [num_channels];

    //////////////////////////////
    // bus handshake
    //////////////////////////////

    // a held request is ignored in the ack cycle, which gives the one cycle ack
    assign req     = wb_cyc && wb_stb && !wb_ack;
    assign wr      = req && wb_we;
    assign wr_ctrl = wr && (wb_adr == reg_ctrl);

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= req;
        end
    end

    always_ff @(posedge clock) begin
        if (req) begin
            wb_dat_r <= rdata;  // held through the ack cycle
        end
    end

    //////////////////////////////
    // ramp controls
    //////////////////////////////

    // pulses are decoded straight from the request so the ramp acts on the ack edge
    assign clr        = wr_ctrl && wb_dat_w[ctrl_clear_bit];
    assign ld         = wr && (wb_adr == reg_load);
    assign load_value = elapsed_t'(wb_dat_w);

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            run <= 1'b0;
        end else if (wr_ctrl && !wb_dat_w[ctrl_clear_bit]) begin
            run <= wb_dat_w[ctrl_run_bit];  // a clear write keeps the run state
        end
    end

    //////////////////////////////
    // tick counters
    //////////////////////////////

    always_comb begin
        for (int k = 0; k < num_channels; k++) begin
            tick_sel[k] = (wb_adr == wb_addr_t'(reg_ticks_base + k));
        end
    end

    always_ff @(posedge clock) begin
        for (int k = 0; k < num_channels; k++) begin
            if (!rst_n) begin
                tick_count[k] <= '0;
            end else if (wr && tick_sel[k]) begin
                tick_count[k] <= '0;
            end else if (ticks[k]) begin
                tick_count[k] <= tick_count[k] + 1'b1;  // wraps at 16 bits
            end
        end
    end

    // read mux, unmapped words and reg_load read as zero
    always_comb begin
        rdata = '0;
        case (wb_adr)
            reg_ctrl:    rdata[ctrl_run_bit] = run;
            reg_status:  rdata = wb_data_t'({done, level});
            reg_elapsed: rdata = wb_data_t'(elapsed);
            default: begin
                for (int k = 0; k < num_channels; k++) begin
                    if (tick_sel[k]) begin
                        rdata = tick_count[k];
                    end
                end
            end
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/pace_regs_pkg.sv
`default_nettype none

package pace_regs_pkg;

    localparam int wb_addr_w = 4;
    localparam int wb_data_w = 16;

    typedef logic [wb_addr_w-1:0] wb_addr_t;  // word address
    typedef logic [wb_data_w-1:0] wb_data_t;

    //////////////////////////////
    // register map
    //////////////////////////////

    localparam wb_addr_t reg_ctrl       = 4'd0;
    localparam wb_addr_t reg_load       = 4'd1;
    localparam wb_addr_t reg_status     = 4'd2;  // level in 3:0, done in 4
    localparam wb_addr_t reg_elapsed    = 4'd3;
    localparam wb_addr_t reg_ticks_base = 4'd4;  // channel k sits at base plus k

    localparam int ctrl_run_bit   = 0;
    localparam int ctrl_clear_bit = 1;  // self clearing, never stored

endpackage

`default_nettype wire

//--- hdl/pace_timer.sv
`timescale 1ns/100ps
`default_nettype none

module pace_timer (
    input  wire               clock,
    input  wire               rst_n,
    input  wire               clr,
    input  wire               run,
    input  wire pace_pkg::period_t period,
    output logic              tick
);

    import pace_pkg::*;

    period_t remaining;  // cycles left in the current interval
    logic    expire;

    // a zero count is treated like one so a bad period cannot stall the channel
    assign expire = run && (remaining <= period_t'(1));

    always_ff @(posedge clock) begin
        if (!rst_n || clr) begin
            remaining <= period;
            tick      <= 1'b0;
        end else begin
            tick <= expire;

            // the period is only sampled here, so a level change waits for the reload
            if (expire) begin
                remaining <= period;
            end else if (run) begin
                remaining <= remaining - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- testbench/game_pace_props.sv
`timescale 1ns/100ps
`default_nettype none

module game_pace_props (
    input wire                     clock,
    input wire                     rst_n,
    input wire                     wb_cyc,
    input wire                     wb_stb,
    input wire                     wb_ack,
    input wire pace_pkg::elapsed_t elapsed,
    input wire pace_pkg::level_t   level
);

    import pace_pkg::*;

    localparam level_t top_level = level_t'(num_levels - 1);

    //////////////////////////////
    // bus handshake
    //////////////////////////////

    ack_one_cycle: assert property (@(posedge clock) disable iff (!rst_n)
        wb_ack |=> !wb_ack)
        else $error("wb_ack stayed high for more than one cycle");

    // ack only ever answers a request seen on the edge before
    ack_after_request: assert property (@(posedge clock) disable iff (!rst_n)
        wb_ack |-> $past(wb_cyc && wb_stb))
        else $error("wb_ack rose without a request in the cycle before");

    //////////////////////////////
    // ramp outputs
    //////////////////////////////

    elapsed_bounded: assert property (@(posedge clock) disable iff (!rst_n)
        elapsed <= elapsed_max)
        else $error("elapsed went past the end of the ramp");

    level_bounded: assert property (@(posedge clock) disable iff (!rst_n)
        level <= top_level)
        else $error("level went past the top level");

endmodule

// the register block sees the ramp outputs on its own inputs
bind pace_regs game_pace_props u_props (
    .clock   (clock),
    .rst_n   (rst_n),
    .wb_cyc  (wb_cyc),
    .wb_stb  (wb_stb),
    .wb_ack  (wb_ack),
    .elapsed (elapsed),
    .level   (level)
);

`default_nettype wire

//--- testbench/tb_game_pace.sv
`timescale 1ns/100ps
`default_nettype none

module tb_game_pace;

    import pace_pkg::*;
    import pace_regs_pkg::*;

    // the whole sequence needs well under 2000 cycles, so this leaves a wide margin
    localparam int timeout_cycles = 20000;

    logic     clock;
    logic     rst_n;
    logic     wb_cyc;
    logic     wb_stb;
    logic     wb_we;
    wb_addr_t wb_adr;
    wb_data_t wb_dat_w;
    wb_data_t wb_dat_r;
    logic     wb_ack;
    logic [num_channels-1:0] ticks;

    integer seed = 32'h5b9b;
    int     cycle_count = 0;
    int     last_ack_cycle = 0;       // cycle of the most recent ack
    int     tick_seen [num_channels];

    game_pace_top u_dut (
        .clock    (clock),
        .rst_n    (rst_n),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .ticks    (ticks)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            fail_now($sformatf("timeout: tests did not finish within %0d cycles",
                timeout_cycles));
        end
    end

    always @(negedge clock) begin
        for (int k = 0; k < num_channels; k++) begin
            if (rst_n && ticks[k]) begin
                tick_seen[k] = tick_seen[k] + 1;  // pulses as the game logic sees them
            end
        end
    end

    //////////////////////////////
    // helpers
    //////////////////////////////

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input wb_data_t expected,
                              input wb_data_t actual);
        if (actual !== expected) begin
            fail_now($sformatf("[ERROR] %s: expected 0x%04h, actual 0x%04h",
                name, expected, actual));
        end
    endtask

    task automatic check_level(input string name, input level_t expected, input level_t actual);
        if (actual !== expected) begin
            fail_now($sformatf("[ERROR] %s: expected level %0d, actual level %0d",
                name, expected, actual));
        end
    endtask

    function int rand_between(input int lo, input int hi);
        return lo + int'({$random(seed)} % (hi - lo + 1));
    endfunction

    // level model taken straight from the ramp rule
    function automatic level_t level_of(input elapsed_t e);
        int q;
        q = int'(e) / step_cycles;
        if (q > num_levels - 1) begin
            q = num_levels - 1;
        end
        return level_t'(q);
    endfunction

    task automatic bus_access(input logic we, input wb_addr_t adr, input wb_data_t data,
                              output wb_data_t rdata);
        @(posedge clock);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= adr;
        wb_dat_w <= data;
        do begin
            @(negedge clock);
        end while (!wb_ack);
        rdata          = wb_dat_r;
        last_ack_cycle = cycle_count;
        @(posedge clock);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic wb_write(input wb_addr_t adr, input wb_data_t data);
        wb_data_t unused;
        bus_access(1'b1, adr, data, unused);
    endtask

    task automatic wb_read(input wb_addr_t adr, output wb_data_t data);
        bus_access(1'b0, adr, '0, data);
    endtask

    //////////////////////////////
    // test sequence
    //////////////////////////////

    initial begin
        wb_data_t rd;
        wb_data_t rd2;
        wb_data_t start_val;
        elapsed_t v;
        int       n;
        int       off;
        int       run_start;
        int       run_cycles;
        int       p;

        rst_n    = 1'b0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        for (int k = 0; k < num_channels; k++) begin
            tick_seen[k] = 0;
        end
        repeat (2) @(posedge clock);
        rst_n <= 1'b1;

        wb_read(reg_elapsed, rd);
        check_word("reset elapsed", '0, rd);
        wb_read(reg_status, rd);
        check_level("reset level", '0, level_t'(rd[3:0]));
        check_word("reset done", '0, wb_data_t'(rd[4]));
        for (int k = 0; k < num_channels; k++) begin
            wb_read(wb_addr_t'(reg_ticks_base + k), rd);
            check_word($sformatf("reset ticks %0d", k), '0, rd);
        end

        for (int i = 0; i < 30; i++) begin
            v = elapsed_t'(rand_between(0, int'(elapsed_max)));
            wb_write(reg_load, wb_data_t'(v));
            wb_read(reg_elapsed, rd);
            check_word("load readback", wb_data_t'(v), rd);
            wb_read(reg_status, rd);
            check_level("load level", level_of(v), level_t'(rd[3:0]));
            check_word("load done", '0, wb_data_t'(rd[4]));
        end

        // run for a while, then freeze and look twice
        wb_write(reg_load, wb_data_t'(rand_between(0, 500)));
        wb_read(reg_elapsed, start_val);
        n = rand_between(10, 200);
        wb_write(reg_ctrl, 16'h0001);
        repeat (n) @(posedge clock);
        wb_write(reg_ctrl, 16'h0000);
        wb_read(reg_elapsed, rd);
        repeat (20) @(posedge clock);
        wb_read(reg_elapsed, rd2);
        check_word("frozen elapsed", rd, rd2);
        if (rd <= start_val) begin
            fail_now($sformatf("elapsed did not advance while running: start %0d, read %0d",
                start_val, rd));
        end
        if (rd > elapsed_max) begin
            fail_now($sformatf("elapsed read %0d, which is past the end of the ramp", rd));
        end
        wb_read(reg_status, rd2);
        check_level("frozen level", level_of(elapsed_t'(rd)), level_t'(rd2[3:0]));

        off = rand_between(1, 20);
        wb_write(reg_load, wb_data_t'(int'(elapsed_max) - off));
        wb_write(reg_ctrl, 16'h0001);
        repeat (off + 10) @(posedge clock);
        wb_read(reg_status, rd);
        check_word("saturated status", wb_data_t'({1'b1, level_t'(num_levels - 1)}), rd);
        wb_write(reg_ctrl, 16'h0000);
        wb_read(reg_elapsed, rd);
        check_word("saturated elapsed", wb_data_t'(elapsed_max), rd);
        wb_read(reg_status, rd);
        check_level("saturated level", level_t'(num_levels - 1), level_t'(rd[3:0]));
        check_word("saturated done", '0, wb_data_t'(rd[4]));

        // the clear restarts the timers while the top level periods are still registered
        wb_write(reg_load, wb_data_t'(elapsed_max));
        wb_write(reg_ctrl, 16'h0002);
        wb_write(reg_load, wb_data_t'(elapsed_max));
        for (int k = 0; k < num_channels; k++) begin
            wb_write(wb_addr_t'(reg_ticks_base + k), '0);
            tick_seen[k] = 0;
        end
        n = rand_between(100, 400);
        wb_write(reg_ctrl, 16'h0001);
        run_start = last_ack_cycle;
        repeat (n) @(posedge clock);
        wb_write(reg_ctrl, 16'h0000);
        run_cycles = last_ack_cycle - run_start;
        for (int k = 0; k < num_channels; k++) begin
            wb_read(wb_addr_t'(reg_ticks_base + k), rd);
            p = int'(period_table[k][num_levels - 1]);
            if (int'(rd) * p < run_cycles - p || int'(rd) * p > run_cycles + p) begin
                fail_now($sformatf("channel %0d ticked %0d times in %0d cycles at period %0d",
                    k, rd, run_cycles, p));
            end
            check_word($sformatf("tick pulses %0d", k), wb_data_t'(tick_seen[k]), rd);
        end

        wb_write(reg_load, wb_data_t'(rand_between(1, int'(elapsed_max))));
        wb_write(reg_ctrl, 16'h0002);
        wb_read(reg_elapsed, rd);
        check_word("clear elapsed", '0, rd);
        wb_read(reg_status, rd);
        check_level("clear level", '0, level_t'(rd[3:0]));
        wb_read(reg_ctrl, rd);
        check_word("clear keeps run off", 16'h0000, rd);
        wb_write(reg_ctrl, 16'h0001);
        wb_write(reg_ctrl, 16'h0002);  // run bit low in the data, but a clear never stores it
        wb_read(reg_ctrl, rd);
        check_word("clear keeps run on", 16'h0001, rd);
        wb_write(reg_ctrl, 16'h0000);

        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire
